//--- hw/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Architectural widths
`define XLEN 64
`define ILEN 32
`define REG_IDX_W 5

// Backend buffer slots on the decode link
`define DECODE_CREDITS 2

// Holds the full credit count
`define CREDIT_W ($clog2(`DECODE_CREDITS + 1))

`endif

//--- hw/rv_isa_pkg.sv
`default_nettype none

`include "decode_macros.svh"

package rv_isa_pkg;

  typedef logic [`ILEN-1:0] instr_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`XLEN-1:0] xlen_t;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD      = 7'b0000011,
    OPCODE_MISC_MEM  = 7'b0001111,
    OPCODE_OP_IMM    = 7'b0010011,
    OPCODE_AUIPC     = 7'b0010111,
    OPCODE_OP_IMM_32 = 7'b0011011,
    OPCODE_STORE     = 7'b0100011,
    OPCODE_OP        = 7'b0110011,
    OPCODE_LUI       = 7'b0110111,
    OPCODE_OP_32     = 7'b0111011,
    OPCODE_BRANCH    = 7'b1100011,
    OPCODE_JALR      = 7'b1100111,
    OPCODE_JAL       = 7'b1101111,
    OPCODE_SYSTEM    = 7'b1110011
  } opcode_e;

  //////////////////////////////
  // Privilege and traps
  //////////////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // ECALL causes sit at 8 + privilege level
  typedef enum logic [3:0] {
    EXC_CAUSE_ILLEGAL_INSN = 4'd2,
    EXC_CAUSE_BREAKPOINT   = 4'd3,
    EXC_CAUSE_ECALL_U      = 4'd8,
    EXC_CAUSE_ECALL_S      = 4'd9,
    EXC_CAUSE_ECALL_M      = 4'd11
  } exc_cause_e;

  typedef struct packed {
    exc_cause_e cause;
    xlen_t      tval;
  } exception_t;

endpackage

`default_nettype wire

//--- hw/decode_pkg.sv
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

  typedef logic [1:0] mem_size_t;
  typedef logic [`CREDIT_W-1:0] credit_cnt_t;

  //////////////////////////////
  // Micro-op encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JUMP,
    OP_MEM,
    OP_MUL,
    OP_DIV
  } op_type_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SCC,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SHIFT
  } alu_op_e;

  typedef enum logic [1:0] {
    SHIFT_OP_SLL,
    SHIFT_OP_SRL,
    SHIFT_OP_SRA
  } shift_op_e;

  // Same encoding as branch funct3
  typedef enum logic [2:0] {
    CC_EQ  = 3'b000,
    CC_NE  = 3'b001,
    CC_LT  = 3'b100,
    CC_GE  = 3'b101,
    CC_LTU = 3'b110,
    CC_GEU = 3'b111
  } cond_e;

  typedef enum logic {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    MUL_OP_MUL,
    MUL_OP_MULH,
    MUL_OP_MULHSU,
    MUL_OP_MULHU
  } mul_op_e;

  typedef enum logic [1:0] {
    DIV_OP_DIV,
    DIV_OP_DIVU,
    DIV_OP_REM,
    DIV_OP_REMU
  } div_op_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  typedef struct packed {
    rv_isa_pkg::xlen_t      pc;
    rv_isa_pkg::instr_t     instr_word;
    logic                   ex_valid;
    rv_isa_pkg::exception_t exception;
  } fetched_instr_t;

  typedef struct packed {
    op_type_e  op_type;
    alu_op_e   alu_op;
    shift_op_e shift_op;
    cond_e     condition;
    mem_op_e   mem_op;
    mul_op_e   mul_op;
    div_op_e   div_op;
    mem_size_t size;
    logic      zeroext;
  } uop_ctrl_t;

  typedef struct packed {
    logic rd_en;
    logic rs1_en;
    logic rs2_en;
  } reg_use_t;

  typedef struct packed {
    logic adder_use_pc;
    logic adder_use_imm;
    logic use_imm;
  } operand_sel_t;

  typedef struct packed {
    rv_isa_pkg::xlen_t      pc;
    uop_ctrl_t              ctrl;
    rv_isa_pkg::reg_idx_t   rd;
    rv_isa_pkg::reg_idx_t   rs1;
    rv_isa_pkg::reg_idx_t   rs2;
    operand_sel_t           operand_sel;
    rv_isa_pkg::xlen_t      immediate;
    logic                   ex_valid;
    rv_isa_pkg::exception_t exception;
  } decoded_instr_t;

endpackage

`default_nettype wire

//--- hw/decode_opcode.sv
`timescale 1ns/1ps
`default_nettype none

module decode_opcode (
  input  rv_isa_pkg::instr_t   instr_i,
  output decode_pkg::uop_ctrl_t ctrl_o,
  output decode_pkg::reg_use_t  reg_use_o,
  output logic                  illegal_o,
  output logic                  ecall_o,
  output logic                  ebreak_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    ctrl_o = '0;
    ctrl_o.op_type = decode_pkg::OP_ALU;
    ctrl_o.alu_op = decode_pkg::ALU_ADD;
    ctrl_o.size = 2'b11;
    reg_use_o = '0;
    illegal_o = 1'b0;
    ecall_o = 1'b0;
    ebreak_o = 1'b0;

    unique case (opcode)
      //////////////////////////////
      // Control transfer
      //////////////////////////////
      rv_isa_pkg::OPCODE_JAL: begin
        ctrl_o.op_type = decode_pkg::OP_JUMP;
        reg_use_o.rd_en = 1'b1;
      end
      rv_isa_pkg::OPCODE_JALR: begin
        ctrl_o.op_type = decode_pkg::OP_JUMP;
        reg_use_o = '{rd_en: 1'b1, rs1_en: 1'b1, rs2_en: 1'b0};
        if (funct3 != 3'b000) illegal_o = 1'b1;
      end
      rv_isa_pkg::OPCODE_BRANCH: begin
        ctrl_o.op_type = decode_pkg::OP_BRANCH;
        ctrl_o.condition = decode_pkg::cond_e'(funct3);
        reg_use_o = '{rd_en: 1'b0, rs1_en: 1'b1, rs2_en: 1'b1};
        // 010 and 011 are unassigned
        if (funct3[2:1] == 2'b01) illegal_o = 1'b1;
      end

      //////////////////////////////
      // Memory
      //////////////////////////////
      rv_isa_pkg::OPCODE_LOAD: begin
        ctrl_o.op_type = decode_pkg::OP_MEM;
        ctrl_o.mem_op = decode_pkg::MEM_LOAD;
        ctrl_o.size = funct3[1:0];
        ctrl_o.zeroext = funct3[2];
        reg_use_o = '{rd_en: 1'b1, rs1_en: 1'b1, rs2_en: 1'b0};
        // No LDU on RV64
        if (funct3 == 3'b111) illegal_o = 1'b1;
      end
      rv_isa_pkg::OPCODE_STORE: begin
        ctrl_o.op_type = decode_pkg::OP_MEM;
        ctrl_o.mem_op = decode_pkg::MEM_STORE;
        ctrl_o.size = funct3[1:0];
        reg_use_o = '{rd_en: 1'b0, rs1_en: 1'b1, rs2_en: 1'b1};
        if (funct3[2]) illegal_o = 1'b1;
      end

      //////////////////////////////
      // Integer ALU
      //////////////////////////////
      rv_isa_pkg::OPCODE_LUI, rv_isa_pkg::OPCODE_AUIPC: begin
        reg_use_o.rd_en = 1'b1;
      end
      rv_isa_pkg::OPCODE_OP_IMM: begin
        reg_use_o = '{rd_en: 1'b1, rs1_en: 1'b1, rs2_en: 1'b0};
        unique case (funct3)
          3'b000: ctrl_o.alu_op = decode_pkg::ALU_ADD;
          3'b010: begin
            ctrl_o.alu_op = decode_pkg::ALU_SCC;
            ctrl_o.condition = decode_pkg::CC_LT;
          end
          3'b011: begin
            ctrl_o.alu_op = decode_pkg::ALU_SCC;
            ctrl_o.condition = decode_pkg::CC_LTU;
          end
          3'b100: ctrl_o.alu_op = decode_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = decode_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = decode_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            ctrl_o.shift_op = decode_pkg::SHIFT_OP_SLL;
            // 6-bit shamt, funct7[0] is shamt[5]
            if (funct7[6:1] != 6'b0) illegal_o = 1'b1;
          end
          default: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            if (funct7[6:1] == 6'b000000) ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRL;
            else if (funct7[6:1] == 6'b010000) ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRA;
            else illegal_o = 1'b1;
          end
        endcase
      end
      rv_isa_pkg::OPCODE_OP_IMM_32: begin
        ctrl_o.size = 2'b10;
        reg_use_o = '{rd_en: 1'b1, rs1_en: 1'b1, rs2_en: 1'b0};
        unique case (funct3)
          3'b000: ctrl_o.alu_op = decode_pkg::ALU_ADD;
          3'b001: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            ctrl_o.shift_op = decode_pkg::SHIFT_OP_SLL;
            if (funct7 != 7'b0) illegal_o = 1'b1;
          end
          3'b101: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            if (funct7 == 7'b0000000) ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRL;
            else if (funct7 == 7'b0100000) ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRA;
            else illegal_o = 1'b1;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      rv_isa_pkg::OPCODE_OP, rv_isa_pkg::OPCODE_OP_32: begin
        reg_use_o = '{rd_en: 1'b1, rs1_en: 1'b1, rs2_en: 1'b1};
        if (opcode == rv_isa_pkg::OPCODE_OP_32) ctrl_o.size = 2'b10;
        unique casez ({funct7, funct3})
          {7'b0000001, 3'b0??}: begin
            ctrl_o.op_type = decode_pkg::OP_MUL;
            ctrl_o.mul_op = decode_pkg::mul_op_e'(funct3[1:0]);
            // Only MULW exists among the word multiplies
            if (opcode == rv_isa_pkg::OPCODE_OP_32 && funct3 != 3'b000) illegal_o = 1'b1;
          end
          {7'b0000001, 3'b1??}: begin
            ctrl_o.op_type = decode_pkg::OP_DIV;
            ctrl_o.div_op = decode_pkg::div_op_e'(funct3[1:0]);
          end
          {7'b0000000, 3'b000}: ctrl_o.alu_op = decode_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = decode_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            ctrl_o.shift_op = decode_pkg::SHIFT_OP_SLL;
          end
          {7'b0000000, 3'b101}: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRL;
          end
          {7'b0100000, 3'b101}: begin
            ctrl_o.alu_op = decode_pkg::ALU_SHIFT;
            ctrl_o.shift_op = decode_pkg::SHIFT_OP_SRA;
          end
          {7'b0000000, 3'b010}: begin
            ctrl_o.alu_op = decode_pkg::ALU_SCC;
            ctrl_o.condition = decode_pkg::CC_LT;
            if (opcode == rv_isa_pkg::OPCODE_OP_32) illegal_o = 1'b1;
          end
          {7'b0000000, 3'b011}: begin
            ctrl_o.alu_op = decode_pkg::ALU_SCC;
            ctrl_o.condition = decode_pkg::CC_LTU;
            if (opcode == rv_isa_pkg::OPCODE_OP_32) illegal_o = 1'b1;
          end
          {7'b0000000, 3'b100}, {7'b0000000, 3'b110}, {7'b0000000, 3'b111}: begin
            if (funct3[1]) ctrl_o.alu_op = funct3[0] ? decode_pkg::ALU_AND : decode_pkg::ALU_OR;
            else ctrl_o.alu_op = decode_pkg::ALU_XOR;
            if (opcode == rv_isa_pkg::OPCODE_OP_32) illegal_o = 1'b1;
          end
          default: illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////
      // Fence and system
      //////////////////////////////
      rv_isa_pkg::OPCODE_MISC_MEM: begin
        // FENCE retires as a plain no-op
        if (funct3 != 3'b000) illegal_o = 1'b1;
      end
      rv_isa_pkg::OPCODE_SYSTEM: begin
        if (instr_i[31:7] == 25'h0) ecall_o = 1'b1;
        else if (instr_i[31:7] == 25'h0002000) ebreak_o = 1'b1;
        else illegal_o = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/decode_fields.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_fields (
  input  rv_isa_pkg::instr_t        instr_i,
  input  decode_pkg::reg_use_t      reg_use_i,
  output rv_isa_pkg::reg_idx_t      rd_o,
  output rv_isa_pkg::reg_idx_t      rs1_o,
  output rv_isa_pkg::reg_idx_t      rs2_o,
  output rv_isa_pkg::xlen_t         immediate_o,
  output decode_pkg::operand_sel_t  operand_sel_o
);

  logic [6:0] opcode;
  rv_isa_pkg::xlen_t i_imm;
  rv_isa_pkg::xlen_t s_imm;
  rv_isa_pkg::xlen_t b_imm;
  rv_isa_pkg::xlen_t u_imm;
  rv_isa_pkg::xlen_t j_imm;

  assign opcode = instr_i[6:0];

  //////////////////////////////
  // Immediate formats
  //////////////////////////////

  assign i_imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign s_imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign b_imm = {{(`XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign u_imm = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
  assign j_imm = {{(`XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    immediate_o = '0;
    operand_sel_o = '0;
    unique case (opcode)
      rv_isa_pkg::OPCODE_LOAD, rv_isa_pkg::OPCODE_JALR: begin
        immediate_o = i_imm;
        operand_sel_o.adder_use_imm = 1'b1;
      end
      rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::OPCODE_OP_IMM_32: begin
        immediate_o = i_imm;
        operand_sel_o = '{adder_use_pc: 1'b0, adder_use_imm: 1'b1, use_imm: 1'b1};
      end
      rv_isa_pkg::OPCODE_STORE: begin
        immediate_o = s_imm;
        operand_sel_o.adder_use_imm = 1'b1;
      end
      // rs1 is zeroed for LUI so the adder yields the bare immediate
      rv_isa_pkg::OPCODE_LUI: begin
        immediate_o = u_imm;
        operand_sel_o.adder_use_imm = 1'b1;
      end
      rv_isa_pkg::OPCODE_AUIPC: begin
        immediate_o = u_imm;
        operand_sel_o = '{adder_use_pc: 1'b1, adder_use_imm: 1'b1, use_imm: 1'b0};
      end
      rv_isa_pkg::OPCODE_BRANCH: begin
        immediate_o = b_imm;
        operand_sel_o = '{adder_use_pc: 1'b1, adder_use_imm: 1'b1, use_imm: 1'b0};
      end
      rv_isa_pkg::OPCODE_JAL: begin
        immediate_o = j_imm;
        operand_sel_o = '{adder_use_pc: 1'b1, adder_use_imm: 1'b1, use_imm: 1'b0};
      end
      default: ;
    endcase
  end

  // Unused indices read as x0
  assign rd_o  = reg_use_i.rd_en  ? instr_i[11:7]  : '0;
  assign rs1_o = reg_use_i.rs1_en ? instr_i[19:15] : '0;
  assign rs2_o = reg_use_i.rs2_en ? instr_i[24:20] : '0;

endmodule

`default_nettype wire

//--- hw/decode_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_credit_counter #(
  parameter int CREDITS = `DECODE_CREDITS
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic take_i,
  input  logic return_i,
  output logic ready_o
);

  // Free slots in the backend buffer
  decode_pkg::credit_cnt_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= decode_pkg::credit_cnt_t'(CREDITS);
    end else begin
      unique case ({take_i, return_i})
        2'b10: count_q <= count_q - 1'b1;
        2'b01: count_q <= count_q + 1'b1;
        default: ;
      endcase
    end
  end

  assign ready_o = (count_q != '0);

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage #(
  parameter int CREDITS = `DECODE_CREDITS
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  rv_isa_pkg::priv_lvl_e      prv_i,
  input  logic                       valid_i,
  input  decode_pkg::fetched_instr_t fetched_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output decode_pkg::decoded_instr_t decoded_o,
  input  logic                       credit_return_i
);

  logic accept;
  logic illegal;
  logic ecall;
  logic ebreak;
  decode_pkg::reg_use_t reg_use;
  decode_pkg::decoded_instr_t decoded_d;

  assign accept = valid_i & ready_o;

  decode_opcode decode_opcode_i (
    .instr_i   (fetched_i.instr_word),
    .ctrl_o    (decoded_d.ctrl),
    .reg_use_o (reg_use),
    .illegal_o (illegal),
    .ecall_o   (ecall),
    .ebreak_o  (ebreak)
  );

  decode_fields decode_fields_i (
    .instr_i       (fetched_i.instr_word),
    .reg_use_i     (reg_use),
    .rd_o          (decoded_d.rd),
    .rs1_o         (decoded_d.rs1),
    .rs2_o         (decoded_d.rs2),
    .immediate_o   (decoded_d.immediate),
    .operand_sel_o (decoded_d.operand_sel)
  );

  decode_credit_counter #(
    .CREDITS (CREDITS)
  ) decode_credit_counter_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .take_i   (accept),
    .return_i (credit_return_i),
    .ready_o  (ready_o)
  );

  //////////////////////////////
  // Exception priority
  //////////////////////////////

  assign decoded_d.pc = fetched_i.pc;
  assign decoded_d.ex_valid = fetched_i.ex_valid | illegal | ecall | ebreak;

  always_comb begin
    decoded_d.exception = '0;
    if (fetched_i.ex_valid) begin
      decoded_d.exception = fetched_i.exception;
    end else if (illegal) begin
      decoded_d.exception.cause = rv_isa_pkg::EXC_CAUSE_ILLEGAL_INSN;
      decoded_d.exception.tval = rv_isa_pkg::xlen_t'(fetched_i.instr_word);
    end else if (ecall) begin
      // 8 + privilege level
      decoded_d.exception.cause = rv_isa_pkg::exc_cause_e'({2'b10, prv_i});
    end else if (ebreak) begin
      decoded_d.exception.cause = rv_isa_pkg::EXC_CAUSE_BREAKPOINT;
    end
  end

  // Output register, one cycle after accept
  always_ff @(posedge clk_i) begin
    if (rst_i) valid_o <= 1'b0;
    else valid_o <= accept;
  end

  always_ff @(posedge clk_i) begin
    if (accept) decoded_o <= decoded_d;
  end

endmodule

`default_nettype wire

//--- bench/decode_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assert (
  input logic                       clk_i,
  input logic                       rst_i,
  input rv_isa_pkg::priv_lvl_e      prv_i,
  input logic                       valid_i,
  input decode_pkg::fetched_instr_t fetched_i,
  input logic                       ready_o,
  input logic                       valid_o,
  input decode_pkg::decoded_instr_t decoded_o,
  input logic                       credit_return_i
);

  int unsigned fail_cnt = 0;

  decode_pkg::fetched_instr_t fetch_q;
  rv_isa_pkg::priv_lvl_e prv_q;
  rv_isa_pkg::instr_t word;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic clean;

  // Last accepted bundle, lines up with decoded_o
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      fetch_q <= fetched_i;
      prv_q <= prv_i;
    end
  end

  assign word = fetch_q.instr_word;
  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign clean = valid_o && !fetch_q.ex_valid;

  function automatic logic [63:0] j_imm(input rv_isa_pkg::instr_t w);
    j_imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // RV64I + M major opcodes handled by the stage
  function automatic logic known_opcode(input logic [6:0] op);
    case (op)
      7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111,
      7'b0110111, 7'b0010111, 7'b0010011, 7'b0011011, 7'b0110011,
      7'b0111011, 7'b0001111, 7'b1110011: known_opcode = 1'b1;
      default: known_opcode = 1'b0;
    endcase
  endfunction

  //////////////////////////////
  // Handshake and credits
  //////////////////////////////

  reset_state: assert property (@(posedge clk_i) $fell(rst_i) |-> !valid_o && ready_o)
    else begin
      fail_cnt++;
      $error("valid_o not low or ready_o not high after reset");
    end

  valid_follows_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o == $past(valid_i && ready_o))
    else begin
      fail_cnt++;
      $error("valid_o does not follow the accept by one cycle");
    end

  return_raises_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    !ready_o && credit_return_i |=> ready_o)
    else begin
      fail_cnt++;
      $error("ready_o stayed low after a credit return");
    end

  //////////////////////////////
  // Fields and micro-op
  //////////////////////////////

  i_imm_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && (opcode == rv_isa_pkg::OPCODE_LOAD ||
      (opcode == rv_isa_pkg::OPCODE_OP_IMM && funct3 == 3'b000)) |->
    decoded_o.immediate == {{52{word[31]}}, word[31:20]} && decoded_o.rd == word[11:7])
    else begin
      fail_cnt++;
      $error("I-format immediate or rd wrong for ADDI or load");
    end

  jal_imm_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && opcode == rv_isa_pkg::OPCODE_JAL |->
    decoded_o.immediate == j_imm(word) && decoded_o.rd == word[11:7])
    else begin
      fail_cnt++;
      $error("J-format immediate or rd wrong for JAL");
    end

  rd_unused: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && (opcode == rv_isa_pkg::OPCODE_STORE || opcode == rv_isa_pkg::OPCODE_BRANCH)
    |-> decoded_o.rd == '0)
    else begin
      fail_cnt++;
      $error("rd not zeroed for store or branch");
    end

  mul_div_split: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && opcode == rv_isa_pkg::OPCODE_OP && word[31:25] == 7'd1 |->
    (funct3[2] ?
      (decoded_o.ctrl.op_type == decode_pkg::OP_DIV && decoded_o.ctrl.div_op == funct3[1:0]) :
      (decoded_o.ctrl.op_type == decode_pkg::OP_MUL && decoded_o.ctrl.mul_op == funct3[1:0])))
    else begin
      fail_cnt++;
      $error("M-extension word decoded to the wrong unit or sub-op");
    end

  //////////////////////////////
  // Exceptions
  //////////////////////////////

  illegal_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    clean && !known_opcode(opcode) |-> decoded_o.ex_valid &&
    decoded_o.exception.cause == rv_isa_pkg::EXC_CAUSE_ILLEGAL_INSN &&
    decoded_o.exception.tval == {32'b0, word})
    else begin
      fail_cnt++;
      $error("Unlisted opcode did not raise an illegal instruction");
    end

  ecall_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    clean && word == 32'h0000_0073 |-> decoded_o.ex_valid &&
    decoded_o.exception.cause == 4'd8 + {2'b00, prv_q})
    else begin
      fail_cnt++;
      $error("ECALL cause is not 8 plus the privilege level");
    end

  upstream_pass: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && fetch_q.ex_valid |->
    decoded_o.ex_valid && decoded_o.exception == fetch_q.exception)
    else begin
      fail_cnt++;
      $error("Fetch exception not passed through unchanged");
    end

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_i (.*);

`default_nettype wire

//--- bench/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  localparam int CREDITS = 2;
  localparam int WAIT_LIMIT = 50;
  localparam int NUM_ROUNDS = 80;

  logic clk_i = 1'b0;
  logic rst_i;
  rv_isa_pkg::priv_lvl_e prv_i;
  logic valid_i;
  decode_pkg::fetched_instr_t fetched_i;
  logic ready_o;
  logic valid_o;
  decode_pkg::decoded_instr_t decoded_o;
  logic credit_return_i;

  int seed;
  int mismatches = 0;
  int timeouts = 0;

  decode_stage #(
    .CREDITS (CREDITS)
  ) decode_stage_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .prv_i           (prv_i),
    .valid_i         (valid_i),
    .fetched_i       (fetched_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .decoded_o       (decoded_o),
    .credit_return_i (credit_return_i)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////
  // Handshake helpers
  //////////////////////////////

  // Outputs are sampled on the falling edge
  task automatic wait_ready();
    int cycles = 0;
    @(negedge clk_i);
    while (!ready_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!ready_o) begin
      timeouts++;
      $display("Timeout at %0t: ready_o never went high", $time);
    end
  endtask

  task automatic wait_valid();
    int cycles = 0;
    @(negedge clk_i);
    while (!valid_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!valid_o) begin
      timeouts++;
      $display("Timeout at %0t: valid_o never went high", $time);
    end
  endtask

  task automatic return_credit();
    repeat ($unsigned($random(seed)) % 4) @(posedge clk_i);
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    @(posedge clk_i);
    credit_return_i <= 1'b0;
  endtask

  task automatic make_word(output rv_isa_pkg::instr_t word, output logic ex_valid,
                           output rv_isa_pkg::exception_t exc);
    logic [31:0] r;
    logic [6:0] unlisted [4];
    int kind;
    // Dropped extensions and reserved space
    unlisted = '{7'b0000111, 7'b0101111, 7'b1010011, 7'b1111111};
    r = $random(seed);
    kind = $unsigned($random(seed)) % 9;
    ex_valid = 1'b0;
    exc = '0;
    case (kind)
      0: word = {r[31:15], 3'b000, r[11:7], 7'b0010011};
      1: word = {r[31:7], 7'b0000011};
      2: word = {r[31:7], 7'b0100011};
      3: word = {r[31:7], 7'b1100011};
      4: word = {r[31:7], 7'b1101111};
      5: word = {7'b0000001, r[24:7], 7'b0110011};
      6: word = {r[31:7], unlisted[r[9:8]]};
      7: word = 32'h0000_0073;
      default: begin
        word = r;
        ex_valid = 1'b1;
        exc.cause = rv_isa_pkg::exc_cause_e'(r[3:0]);
        exc.tval = {$random(seed), $random(seed)};
      end
    endcase
  endtask

  task automatic issue(input rv_isa_pkg::instr_t word, input logic ex_valid,
                       input rv_isa_pkg::exception_t exc);
    logic [1:0] p;
    p = $random(seed);
    wait_ready();
    @(posedge clk_i);
    case (p)
      2'd0: prv_i <= rv_isa_pkg::PRIV_LVL_U;
      2'd1: prv_i <= rv_isa_pkg::PRIV_LVL_S;
      default: prv_i <= rv_isa_pkg::PRIV_LVL_M;
    endcase
    valid_i <= 1'b1;
    fetched_i <= '{pc: {$random(seed), $random(seed)}, instr_word: word,
                   ex_valid: ex_valid, exception: exc};
    // Accept edge
    @(posedge clk_i);
    valid_i <= 1'b0;
    wait_valid();
    return_credit();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rv_isa_pkg::instr_t word;
    rv_isa_pkg::exception_t exc;
    logic ex_valid;
    logic stuck;
    int accepts;
    int cycles;
    int assert_fails;

    seed = 32'h6151;
    rst_i = 1'b1;
    prv_i = rv_isa_pkg::PRIV_LVL_M;
    valid_i = 1'b0;
    fetched_i = '0;
    credit_return_i = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Hold an ADDI on the input until the credits run dry
    @(posedge clk_i);
    valid_i <= 1'b1;
    fetched_i <= '{pc: 64'h1000, instr_word: 32'h0050_0093, ex_valid: 1'b0, exception: '0};
    accepts = 0;
    cycles = 0;
    @(negedge clk_i);
    while (ready_o && cycles < WAIT_LIMIT) begin
      accepts++;
      @(negedge clk_i);
      cycles++;
    end
    stuck = ready_o;
    @(posedge clk_i);
    valid_i <= 1'b0;
    if (stuck) begin
      timeouts++;
      $display("Timeout at %0t: ready_o never fell during the burst", $time);
    end else if (accepts != CREDITS) begin
      mismatches++;
      $display("Mismatch at %0t: ready_o fell after %0d accepts, expected %0d",
               $time, accepts, CREDITS);
    end

    // Give every credit back
    credit_return_i <= 1'b1;
    repeat (CREDITS) @(posedge clk_i);
    credit_return_i <= 1'b0;

    for (int i = 0; i < NUM_ROUNDS; i++) begin
      make_word(word, ex_valid, exc);
      issue(word, ex_valid, exc);
    end

    repeat (4) @(posedge clk_i);
    assert_fails = decode_stage_i.decode_stage_assert_i.fail_cnt;
    $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, assert_fails);
    if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/decode_opcode.sv
hw/decode_fields.sv
hw/decode_credit_counter.sv
hw/decode_stage.sv
bench/decode_stage_assert.sv
bench/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/decode_pkg.sv
      - hw/decode_opcode.sv
      - hw/decode_fields.sv
      - hw/decode_credit_counter.sv
      - hw/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_assert.sv
      - bench/decode_stage_tb.sv
